//--- src.f
verilog/mdio_pkg.sv
verilog/phy_regs_pkg.sv
verilog/mdc_clock_gen.sv
verilog/mdio_frame_shifter.sv
verilog/phy_init_ctrl.sv
verilog/phy_mgmt_top.sv
bench/phy_mgmt_checker.sv
bench/phy_mgmt_tb.sv

//--- Makefile
# Verilator build and run for the PHY management project

VERILATOR ?= verilator
TOP       ?= phy_mgmt_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= FAIL: see errors above
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/phy_mgmt_tb.sv
/*
 * PHY management testbench
 * runs the startup MDIO configuration under several reset scenarios,
 * decodes every write frame on the pins and checks it against the
 * expected REGCR/ADDAR sequence
 */
`timescale 1ns/100ps

module phy_mgmt_tb;

    localparam int unsigned STARTUP_DELAY   = 40;
    localparam int unsigned CLK_PERIOD      = 8;
    localparam int unsigned N_FRAMES        = 12;
    localparam int unsigned FRAME_LEN       = 64;
    localparam int unsigned MDC_PERIOD      = 8;
    localparam int unsigned N_SCEN          = 3;
    // two frame lengths with the bus quiet after init_done
    localparam int unsigned QUIET_CYCLES    = 2 * FRAME_LEN * MDC_PERIOD;
    localparam int unsigned WATCHDOG_CYCLES = (STARTUP_DELAY + N_FRAMES * 600) * N_SCEN * 2;

    typedef struct packed {
        logic       reset_mid;
        logic [3:0] after_frame;
    } scenario_t;

    // clean run, reset after frame 5, reset after frame 11
    localparam scenario_t SCENARIOS [0:N_SCEN-1] = '{
        '{1'b0, 4'd0},
        '{1'b1, 4'd5},
        '{1'b1, 4'd11}
    };

    logic clk_125mhz_int = 1'b0;
    logic rst_125mhz_int = 1'b1;
    logic phy_mdc_o;
    logic phy_mdio_o;
    logic phy_mdio_t_o;
    logic init_done_o;

    logic [4:0]  exp_reg  [0:N_FRAMES-1];
    logic [15:0] exp_data [0:N_FRAMES-1];
    logic [63:0] frame_q [$];

    int unsigned checks = 0;
    int unsigned errors = 0;

    // frame monitor state
    int unsigned cyc                = 0;
    int unsigned release_cyc        = 0;
    int unsigned last_rise_cyc      = 0;
    int unsigned rises_in_frame     = 0;
    int unsigned frames_since_reset = 0;
    logic [63:0] shift_reg          = '0;
    logic        in_reset           = 1'b1;
    logic        first_rise_seen    = 1'b0;
    logic        mdc_prev           = 1'b0;
    logic        mdio_t_prev        = 1'b1;
    logic        done_prev          = 1'b0;

    phy_mgmt_top #(
        .startup_delay (STARTUP_DELAY)
    ) dut_i (
        .clk_125mhz_int (clk_125mhz_int),
        .rst_125mhz_int (rst_125mhz_int),
        .phy_mdc_o      (phy_mdc_o),
        .phy_mdio_o     (phy_mdio_o),
        .phy_mdio_t_o   (phy_mdio_t_o),
        .init_done_o    (init_done_o)
    );

    always #(CLK_PERIOD / 2) clk_125mhz_int = ~clk_125mhz_int;

    task automatic check_eq(input logic [63:0] actual, input logic [63:0] expected,
                            input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH at %t: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
        end
    endtask

    // four clause-22 writes per extended register
    task automatic build_expected();
        logic [15:0] ext_addr [0:2];
        logic [15:0] ext_val  [0:2];
        int unsigned n;
        ext_addr[0] = 16'h0031;
        ext_val[0]  = 16'h0070;
        ext_addr[1] = 16'h00D3;
        ext_val[1]  = 16'h4000;
        ext_addr[2] = 16'h016F;
        ext_val[2]  = 16'h0015;
        for (int e = 0; e < 3; e++) begin
            n = 4 * e;
            exp_reg[n]      = 5'h0D;
            exp_data[n]     = 16'h001F;
            exp_reg[n + 1]  = 5'h0E;
            exp_data[n + 1] = ext_addr[e];
            exp_reg[n + 2]  = 5'h0D;
            exp_data[n + 2] = 16'h401F;
            exp_reg[n + 3]  = 5'h0E;
            exp_data[n + 3] = ext_val[e];
        end
    endtask

    task automatic check_frame(input logic [63:0] frame, input int unsigned idx);
        check_eq(frame[63:32], 32'hFFFF_FFFF, $sformatf("frame %0d preamble", idx));
        check_eq(frame[31:30], 2'b01, $sformatf("frame %0d start code", idx));
        check_eq(frame[29:28], 2'b01, $sformatf("frame %0d opcode", idx));
        check_eq(frame[27:23], 5'h03, $sformatf("frame %0d PHY address", idx));
        check_eq(frame[22:18], exp_reg[idx], $sformatf("frame %0d register", idx));
        check_eq(frame[17:16], 2'b10, $sformatf("frame %0d turnaround", idx));
        check_eq(frame[15:0], exp_data[idx], $sformatf("frame %0d data", idx));
    endtask

    // reset held over two rising edges, outputs checked before release
    task automatic apply_reset();
        @(negedge clk_125mhz_int);
        rst_125mhz_int <= 1'b1;
        repeat (2) @(negedge clk_125mhz_int);
        check_eq(phy_mdc_o, 1'b0, "MDC in reset");
        check_eq(phy_mdio_t_o, 1'b1, "MDIO enable in reset");
        check_eq(phy_mdio_o, 1'b1, "MDIO data in reset");
        check_eq(init_done_o, 1'b0, "init_done in reset");
        frame_q.delete();
        rst_125mhz_int <= 1'b0;
    endtask

    task automatic wait_frame(output logic [63:0] frame);
        while (frame_q.size() == 0) begin
            @(posedge clk_125mhz_int);
        end
        frame = frame_q.pop_front();
    endtask

    task automatic wait_done();
        do begin
            @(negedge clk_125mhz_int);
        end while (init_done_o !== 1'b1);
    endtask

    // frame decoder, sampled at the falling clock edge where the pins are stable
    always @(negedge clk_125mhz_int) begin
        cyc = cyc + 1;
        if (rst_125mhz_int) begin
            in_reset           = 1'b1;
            first_rise_seen    = 1'b0;
            rises_in_frame     = 0;
            frames_since_reset = 0;
        end else begin
            if (in_reset) begin
                release_cyc = cyc;
                in_reset    = 1'b0;
            end
            if (!phy_mdio_t_o && mdio_t_prev) begin
                rises_in_frame = 0;
            end
            if (phy_mdc_o && !mdc_prev) begin
                check_eq(phy_mdio_t_o, 1'b0, "MDC rising edge with MDIO released");
                if (!first_rise_seen) begin
                    check_eq(cyc - release_cyc >= STARTUP_DELAY, 1'b1,
                             "first MDC edge before the startup delay");
                    first_rise_seen = 1'b1;
                end
                if (rises_in_frame > 0) begin
                    check_eq(cyc - last_rise_cyc, MDC_PERIOD, "MDC period");
                end
                last_rise_cyc  = cyc;
                shift_reg      = {shift_reg[62:0], phy_mdio_o};
                rises_in_frame = rises_in_frame + 1;
                if (rises_in_frame == FRAME_LEN) begin
                    frame_q.push_back(shift_reg);
                    frames_since_reset = frames_since_reset + 1;
                    check_eq(frames_since_reset <= N_FRAMES, 1'b1, "frame count since reset");
                end
            end
            if (phy_mdio_t_o && !mdio_t_prev) begin
                check_eq(rises_in_frame, FRAME_LEN, "MDC rising edges in frame");
            end
            if (init_done_o && !done_prev) begin
                check_eq(frames_since_reset, N_FRAMES, "frames before init_done");
            end
        end
        mdc_prev    = phy_mdc_o;
        mdio_t_prev = phy_mdio_t_o;
        done_prev   = init_done_o;
    end

    initial begin
        logic [63:0] frame;
        int unsigned got;
        int unsigned low_cycles;
        logic        pulsed;
        $timeformat(-9, 1, " ns", 10);
        build_expected();
        for (int s = 0; s < N_SCEN; s++) begin
            apply_reset();
            got    = 0;
            pulsed = 1'b0;
            while (got < N_FRAMES) begin
                wait_frame(frame);
                check_frame(frame, got);
                got = got + 1;
                if (SCENARIOS[s].reset_mid && !pulsed && got == SCENARIOS[s].after_frame) begin
                    // the sequence starts over from the first entry
                    apply_reset();
                    pulsed = 1'b1;
                    got    = 0;
                end
            end
            wait_done();
            low_cycles = 0;
            repeat (QUIET_CYCLES) begin
                @(negedge clk_125mhz_int);
                if (init_done_o !== 1'b1) begin
                    low_cycles = low_cycles + 1;
                end
            end
            check_eq(low_cycles, 0, "cycles with init_done low after it rose");
            check_eq(frame_q.size(), 0, "frames after init_done");
            check_eq(phy_mdio_t_o, 1'b1, "MDIO released after init");
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_125mhz_int);
        $display("watchdog expired after %0d cycles, the init sequence did not finish",
                 WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- bench/phy_mgmt_checker.sv
/*
 * MDIO pin checker
 * concurrent assertions on the management pins of the top level
 */
`timescale 1ns/100ps

module phy_mgmt_checker (
    input logic clk_125mhz_int,
    input logic rst_125mhz_int,
    input logic phy_mdc_i,
    input logic phy_mdio_i,
    input logic phy_mdio_t_i,
    input logic init_done_i
);

    // MDC parked low whenever the pad is released
    mdc_low_when_released: assert property (
        @(posedge clk_125mhz_int) disable iff (rst_125mhz_int)
        phy_mdio_t_i |-> !phy_mdc_i
    ) else $error("MDC high while MDIO is released");

    // PHY samples on the rising edge, data only moves while MDC is low
    mdio_stable_mdc_high: assert property (
        @(posedge clk_125mhz_int) disable iff (rst_125mhz_int)
        phy_mdc_i |-> $stable(phy_mdio_i)
    ) else $error("MDIO changed while MDC was high");

    // sticky until the next reset
    done_sticky: assert property (
        @(posedge clk_125mhz_int)
        (init_done_i && !rst_125mhz_int) |=> init_done_i
    ) else $error("init_done fell without a reset");

endmodule

bind phy_mgmt_top phy_mgmt_checker checker_i (
    .clk_125mhz_int (clk_125mhz_int),
    .rst_125mhz_int (rst_125mhz_int),
    .phy_mdc_i      (phy_mdc_o),
    .phy_mdio_i     (phy_mdio_o),
    .phy_mdio_t_i   (phy_mdio_t_o),
    .init_done_i    (init_done_o)
);

//--- verilog/phy_mgmt_top.sv
/*
 * PHY management top level
 * startup configuration of the copper PHY over MDIO, the
 * pad output and its enable are brought out for the board tristate
 */
`timescale 1ns/100ps

module phy_mgmt_top #(
    parameter int unsigned startup_delay = 20'hFFFFF
) (
    input  logic clk_125mhz_int,
    input  logic rst_125mhz_int,
    output logic phy_mdc_o,
    output logic phy_mdio_o,
    output logic phy_mdio_t_o,
    output logic init_done_o
);

    // command channel
    logic                              cmd_valid;
    logic                              cmd_ready;
    logic [mdio_pkg::REG_ADDR_W-1:0]   cmd_reg_addr;
    logic [mdio_pkg::DATA_W-1:0]       cmd_data;

    // shifter to MDC generator
    logic                              mdc_run;
    logic                              mdc_fall_stb;

    phy_init_ctrl #(
        .startup_delay (startup_delay)
    ) phy_init_ctrl_i (
        .clk_125mhz_int (clk_125mhz_int),
        .rst_125mhz_int (rst_125mhz_int),
        .cmd_ready_i    (cmd_ready),
        .cmd_valid_o    (cmd_valid),
        .cmd_reg_addr_o (cmd_reg_addr),
        .cmd_data_o     (cmd_data),
        .init_done_o    (init_done_o)
    );

    mdio_frame_shifter mdio_frame_shifter_i (
        .clk_125mhz_int (clk_125mhz_int),
        .rst_125mhz_int (rst_125mhz_int),
        .cmd_valid_i    (cmd_valid),
        .cmd_reg_addr_i (cmd_reg_addr),
        .cmd_data_i     (cmd_data),
        .fall_stb_i     (mdc_fall_stb),
        .cmd_ready_o    (cmd_ready),
        .run_o          (mdc_run),
        .mdio_o         (phy_mdio_o),
        .mdio_t_o       (phy_mdio_t_o)
    );

    mdc_clock_gen mdc_clock_gen_i (
        .clk_125mhz_int (clk_125mhz_int),
        .rst_125mhz_int (rst_125mhz_int),
        .run_i          (mdc_run),
        .mdc_o          (phy_mdc_o),
        .fall_stb_o     (mdc_fall_stb)
    );

endmodule

//--- verilog/phy_init_ctrl.sv
/*
 * PHY init sequencer
 * waits out the startup delay, then writes the extended PHY
 * registers through REGCR/ADDAR, four clause-22 writes per entry
 */
`timescale 1ns/100ps

module phy_init_ctrl #(
    parameter int unsigned startup_delay = 20'hFFFFF
) (
    input  logic                              clk_125mhz_int,
    input  logic                              rst_125mhz_int,
    input  logic                              cmd_ready_i,
    output logic                              cmd_valid_o,
    output logic [mdio_pkg::REG_ADDR_W-1:0]   cmd_reg_addr_o,
    output logic [mdio_pkg::DATA_W-1:0]       cmd_data_o,
    output logic                              init_done_o
);

    localparam int DELAY_W = (startup_delay > 0) ? $clog2(startup_delay + 1) : 1;
    localparam int IDX_W   = (phy_regs_pkg::EXT_WRITES > 1) ?
                             $clog2(phy_regs_pkg::EXT_WRITES) : 1;

    phy_regs_pkg::init_state_e state;
    phy_regs_pkg::ext_write_t  entry;

    logic [DELAY_W-1:0]                delay_cnt;
    logic [IDX_W-1:0]                  idx;
    logic [1:0]                        step;
    logic                              all_sent;
    logic                              xfer;
    logic                              load_cmd;
    logic [mdio_pkg::REG_ADDR_W-1:0]   sel_reg;
    logic [mdio_pkg::DATA_W-1:0]       sel_data;

    assign xfer     = cmd_valid_o && cmd_ready_i;
    assign load_cmd = (state == phy_regs_pkg::ISSUE) && cmd_ready_i && !all_sent;
    assign entry    = phy_regs_pkg::EXT_WRITE_TABLE[idx];

    // REGCR addr mode, ADDAR address, REGCR data mode, ADDAR data
    always_comb begin
        case (step)
            2'd0: begin
                sel_reg  = phy_regs_pkg::REG_REGCR;
                sel_data = phy_regs_pkg::REGCR_ADDR_MODE;
            end
            2'd1: begin
                sel_reg  = phy_regs_pkg::REG_ADDAR;
                sel_data = entry.reg_addr;
            end
            2'd2: begin
                sel_reg  = phy_regs_pkg::REG_REGCR;
                sel_data = phy_regs_pkg::REGCR_DATA_MODE;
            end
            default: begin
                sel_reg  = phy_regs_pkg::REG_ADDAR;
                sel_data = entry.data;
            end
        endcase
    end

    always_ff @(posedge clk_125mhz_int) begin
        if (rst_125mhz_int) begin
            state       <= phy_regs_pkg::WAIT_DELAY;
            delay_cnt   <= DELAY_W'(startup_delay);
            idx         <= '0;
            step        <= 2'd0;
            all_sent    <= 1'b0;
            cmd_valid_o <= 1'b0;
        end else begin
            case (state)
                phy_regs_pkg::WAIT_DELAY: begin
                    if (delay_cnt == '0) begin
                        state <= phy_regs_pkg::ISSUE;
                    end else begin
                        delay_cnt <= delay_cnt - 1'b1;
                    end
                end
                phy_regs_pkg::ISSUE: begin
                    // ready back means the previous frame has left the pin
                    if (cmd_ready_i) begin
                        if (all_sent) begin
                            state <= phy_regs_pkg::DONE;
                        end else begin
                            cmd_valid_o <= 1'b1;
                            state       <= phy_regs_pkg::WAIT_ACCEPT;
                        end
                    end
                end
                phy_regs_pkg::WAIT_ACCEPT: begin
                    if (xfer) begin
                        cmd_valid_o <= 1'b0;
                        step        <= step + 1'b1;
                        if (step == 2'd3) begin
                            if (idx == IDX_W'(phy_regs_pkg::EXT_WRITES - 1)) begin
                                all_sent <= 1'b1;
                            end else begin
                                idx <= idx + 1'b1;
                            end
                        end
                        state <= phy_regs_pkg::ISSUE;
                    end
                end
                phy_regs_pkg::DONE: begin
                    state <= phy_regs_pkg::DONE;
                end
                default: begin
                    state <= phy_regs_pkg::WAIT_DELAY;
                end
            endcase
        end
    end

    // fields only change while valid is low
    always_ff @(posedge clk_125mhz_int) begin
        if (load_cmd) begin
            cmd_reg_addr_o <= sel_reg;
            cmd_data_o     <= sel_data;
        end
    end

    assign init_done_o = (state == phy_regs_pkg::DONE);

endmodule

//--- verilog/mdio_frame_shifter.sv
/*
 * MDIO write frame shifter
 * takes one write command over valid/ready, builds the 64-bit
 * clause-22 frame and shifts it out MSB first, one bit per MDC period
 */
`timescale 1ns/100ps

module mdio_frame_shifter (
    input  logic                              clk_125mhz_int,
    input  logic                              rst_125mhz_int,
    input  logic                              cmd_valid_i,
    input  logic [mdio_pkg::REG_ADDR_W-1:0]   cmd_reg_addr_i,
    input  logic [mdio_pkg::DATA_W-1:0]       cmd_data_i,
    input  logic                              fall_stb_i,
    output logic                              cmd_ready_o,
    output logic                              run_o,
    output logic                              mdio_o,
    output logic                              mdio_t_o
);

    localparam int FRAME_BITS = mdio_pkg::FRAME_BITS;
    localparam int CNT_W      = $clog2(FRAME_BITS);

    logic [FRAME_BITS-1:0] frame_next;
    // bits still to go after the one on the pin
    logic [FRAME_BITS-2:0] frame_q;
    logic [CNT_W-1:0]      bit_cnt;
    logic                  busy;
    logic                  xfer;
    logic                  last_bit;

    assign xfer     = cmd_valid_i && !busy;
    assign last_bit = (bit_cnt == CNT_W'(FRAME_BITS - 1));

    assign frame_next = {
        {mdio_pkg::PREAMBLE_BITS{1'b1}},
        mdio_pkg::START_CODE,
        mdio_pkg::MDIO_OP_WRITE,
        phy_regs_pkg::PHY_ADDR,
        cmd_reg_addr_i,
        mdio_pkg::TURNAROUND_WRITE,
        cmd_data_i
    };

    // one busy flag drives the handshake, MDC run and the pad enable
    assign cmd_ready_o = !busy;
    assign run_o       = busy;
    assign mdio_t_o    = !busy;

    always_ff @(posedge clk_125mhz_int) begin
        if (rst_125mhz_int) begin
            busy    <= 1'b0;
            bit_cnt <= '0;
            mdio_o  <= 1'b1;
        end else if (xfer) begin
            busy    <= 1'b1;
            bit_cnt <= '0;
            mdio_o  <= frame_next[FRAME_BITS-1];
        end else if (busy && fall_stb_i) begin
            if (last_bit) begin
                // 64th falling edge, frame complete
                busy   <= 1'b0;
                mdio_o <= 1'b1;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
                mdio_o  <= frame_q[FRAME_BITS-2];
            end
        end
    end

    always_ff @(posedge clk_125mhz_int) begin
        if (xfer) begin
            frame_q <= frame_next[FRAME_BITS-2:0];
        end else if (busy && fall_stb_i) begin
            frame_q <= {frame_q[FRAME_BITS-3:0], 1'b0};
        end
    end

endmodule

//--- verilog/mdc_clock_gen.sv
/*
 * MDC clock generator
 * divides the system clock while a frame is running and
 * flags every falling edge of MDC for the frame shifter
 */
`timescale 1ns/100ps

module mdc_clock_gen (
    input  logic clk_125mhz_int,
    input  logic rst_125mhz_int,
    input  logic run_i,
    output logic mdc_o,
    output logic fall_stb_o
);

    localparam int CNT_W = $clog2(mdio_pkg::MDC_PRESCALE + 1);

    logic [CNT_W-1:0] pre_cnt;
    logic             half_end;

    assign half_end = (pre_cnt == CNT_W'(mdio_pkg::MDC_PRESCALE));

    always_ff @(posedge clk_125mhz_int) begin
        if (rst_125mhz_int) begin
            pre_cnt    <= '0;
            mdc_o      <= 1'b0;
            fall_stb_o <= 1'b0;
        end else if (!run_i) begin
            // idle, MDC parked low
            pre_cnt    <= '0;
            mdc_o      <= 1'b0;
            fall_stb_o <= 1'b0;
        end else begin
            fall_stb_o <= 1'b0;
            if (half_end) begin
                pre_cnt <= '0;
                mdc_o   <= ~mdc_o;
                // strobe lines up with MDC going low
                fall_stb_o <= mdc_o;
            end else begin
                pre_cnt <= pre_cnt + 1'b1;
            end
        end
    end

endmodule

//--- verilog/phy_regs_pkg.sv
/*
 * Gigabit copper PHY register map
 * clause-22 indirect access registers, the extended register writes
 * done at startup and the init sequencer states
 */
package phy_regs_pkg;

    // strapped management address of the PHY
    localparam logic [mdio_pkg::PHY_ADDR_W-1:0] PHY_ADDR = 5'h03;

    // indirect access to the MMD register space
    localparam logic [mdio_pkg::REG_ADDR_W-1:0] REG_REGCR = 5'h0D;
    localparam logic [mdio_pkg::REG_ADDR_W-1:0] REG_ADDAR = 5'h0E;

    // REGCR function field, device address 0x1F
    localparam logic [mdio_pkg::DATA_W-1:0] REGCR_ADDR_MODE = 16'h001F;
    localparam logic [mdio_pkg::DATA_W-1:0] REGCR_DATA_MODE = 16'h401F;

    localparam int unsigned EXT_WRITES = 3;

    typedef struct packed {
        logic [mdio_pkg::DATA_W-1:0] reg_addr;
        logic [mdio_pkg::DATA_W-1:0] data;
    } ext_write_t;

    // CFG4: SGMII autoneg timer to 11 ms
    // SGMIICTL1: SGMII clock output on
    // 10M_SGMII_CFG: allow 10 Mbps over SGMII
    localparam ext_write_t EXT_WRITE_TABLE [0:EXT_WRITES-1] = '{
        '{reg_addr: 16'h0031, data: 16'h0070},
        '{reg_addr: 16'h00D3, data: 16'h4000},
        '{reg_addr: 16'h016F, data: 16'h0015}
    };

    typedef enum logic [1:0] {
        WAIT_DELAY,
        ISSUE,
        WAIT_ACCEPT,
        DONE
    } init_state_e;

endpackage

//--- verilog/mdio_pkg.sv
/*
 * MDIO frame format
 * clause-22 frame fields, opcode encoding and the MDC prescale
 * shared by the frame shifter and the MDC generator
 */
package mdio_pkg;

    // clause-22 opcode field
    typedef enum logic [1:0] {
        MDIO_OP_WRITE = 2'b01,
        MDIO_OP_READ  = 2'b10
    } mdio_op_e;

    // all ones before every frame
    localparam int unsigned PREAMBLE_BITS = 32;

    // preamble + ST + OP + PHYAD + REGAD + TA + DATA
    localparam int unsigned FRAME_BITS = 64;

    localparam logic [1:0] START_CODE = 2'b01;

    // master drives 1 then 0 on a write
    localparam logic [1:0] TURNAROUND_WRITE = 2'b10;

    // field widths
    localparam int unsigned PHY_ADDR_W = 5;
    localparam int unsigned REG_ADDR_W = 5;
    localparam int unsigned DATA_W     = 16;

    // MDC half period is MDC_PRESCALE+1 clocks, 8 clocks per MDC period
    localparam int unsigned MDC_PRESCALE = 3;

endpackage
